// File: hw/lb_slave_pkg.sv
/* Local bus register block definitions
   Bus widths, page numbers, register indices and fixed read values */
`default_nettype none

package lb_slave_pkg;

	// Bus widths
	localparam int lb_addr_w = 24;
	localparam int lb_data_w = 32;

	// Address page, taken from address bits 23 to 16
	localparam logic [7:0] page_status = 8'd0;
	localparam logic [7:0] page_direct = 8'd5;

	// Status bank indices, address bits 3 to 0
	localparam logic [3:0] reg_hello_0     = 4'd0;
	localparam logic [3:0] reg_hello_1     = 4'd1;
	localparam logic [3:0] reg_hello_2     = 4'd2;
	localparam logic [3:0] reg_hello_3     = 4'd3;
	localparam logic [3:0] reg_fault_count = 4'd4;
	localparam logic [3:0] reg_tx_done     = 4'd6;
	localparam logic [3:0] reg_rx_status   = 4'd7;
	localparam logic [3:0] reg_uptime      = 4'd8;

	// Identification string, four characters per word
	localparam logic [31:0] hello_word_0 = "Hell";
	localparam logic [31:0] hello_word_1 = "o wo";
	localparam logic [31:0] hello_word_2 = "rld!";
	localparam logic [31:0] hello_word_3 = "(::)";

	// Returned for status indices that hold nothing
	localparam logic [31:0] status_default = "zzzz";

	// Returned for pages that are not decoded
	localparam logic [31:0] unmapped_value = 32'hdeadbeef;

	// Direct-write indices, address bits 4 to 0
	localparam logic [4:0] wr_led_user    = 5'd1;
	localparam logic [4:0] wr_led1_duty   = 5'd2;
	localparam logic [4:0] wr_led2_duty   = 5'd3;
	localparam logic [4:0] wr_rx_hbank    = 5'd5;
	localparam logic [4:0] wr_misc_config = 5'd8;

endpackage

`default_nettype wire

// File: hw/lb_status_bank.sv
/* Status bank, first read cycle of the status page
   Holds the fault and uptime counters and the resynchronized MAC status */
`timescale 1ns/100ps
`default_nettype none

module lb_status_bank (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [3:0]  addr,
	input  wire         do_rd,
	input  wire         xdomain_fault,
	input  wire         tx_mac_done,
	input  wire  [1:0]  rx_mac_buf_status,
	input  wire         led_tick,
	output logic [lb_slave_pkg::lb_data_w-1:0] bank_word
);

	logic [15:0] fault_count;
	logic [31:0] uptime;
	logic        tx_mac_done_r;
	logic [1:0]  rx_mac_buf_status_r;
	logic [31:0] sel_word;

	// Cross-domain fault pulses, one count per high cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 16'd1;
		end
	end

	// Coarse uptime, advanced by the PWM counter carry
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 32'd1;
		end
	end

	// Bring the MAC status into the bus clock domain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_mac_done_r       <= 1'b0;
			rx_mac_buf_status_r <= 2'b00;
		end else begin
			tx_mac_done_r       <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	always_comb begin
		case (addr)
			lb_slave_pkg::reg_hello_0:     sel_word = lb_slave_pkg::hello_word_0;
			lb_slave_pkg::reg_hello_1:     sel_word = lb_slave_pkg::hello_word_1;
			lb_slave_pkg::reg_hello_2:     sel_word = lb_slave_pkg::hello_word_2;
			lb_slave_pkg::reg_hello_3:     sel_word = lb_slave_pkg::hello_word_3;
			lb_slave_pkg::reg_fault_count: sel_word = {16'd0, fault_count};
			lb_slave_pkg::reg_tx_done:     sel_word = {31'd0, tx_mac_done_r};
			lb_slave_pkg::reg_rx_status:   sel_word = {30'd0, rx_mac_buf_status_r};
			lb_slave_pkg::reg_uptime:      sel_word = uptime;
			default:                       sel_word = lb_slave_pkg::status_default;
		endcase
	end

	// Loaded only on a read so the word holds until the second stage takes it
	always_ff @(posedge clk) begin
		if (do_rd) begin
			bank_word <= sel_word;
		end
	end

endmodule

`default_nettype wire

// File: hw/lb_ctrl_bank.sv
/* Direct-write control bank
   Decodes page 5 writes into control registers and runs the LED PWM */
`timescale 1ns/100ps
`default_nettype none

module lb_ctrl_bank #(
	parameter int led_cw = 10
) (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [lb_slave_pkg::lb_addr_w-1:0] addr,
	input  wire         control_strobe,
	input  wire         control_rd,
	input  wire  [lb_slave_pkg::lb_data_w-1:0] data_out,
	output logic        local_write,
	output logic        led_tick,
	output logic        led_user_mode,
	output logic        led1,
	output logic        led2,
	output logic        rx_mac_hbank,
	output logic [7:0]  misc_config
);

	// Comparison width covers both the counter and duty times four
	localparam int cmp_w = (led_cw > 10) ? led_cw : 10;

	logic [7:0]        led1_duty;
	logic [7:0]        led2_duty;
	logic [led_cw-1:0] led_cc;
	logic [led_cw:0]   cc_next;
	logic [cmp_w-1:0]  cc_ext;
	logic [cmp_w-1:0]  duty1_ext;
	logic [cmp_w-1:0]  duty2_ext;
	logic [4:0]        wr_index;

	// Mirror write enable and register decode share this qualifier
	assign local_write = control_strobe & ~control_rd &
		(addr[lb_slave_pkg::lb_addr_w-1:16] == lb_slave_pkg::page_direct);
	assign wr_index = addr[4:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_user_mode <= 1'b0;
			led1_duty     <= 8'd0;
			led2_duty     <= 8'd0;
			rx_mac_hbank  <= 1'b1;
			misc_config   <= 8'd0;
		end else if (local_write) begin
			case (wr_index)
				lb_slave_pkg::wr_led_user:    led_user_mode <= data_out[0];
				lb_slave_pkg::wr_led1_duty:   led1_duty     <= data_out[7:0];
				lb_slave_pkg::wr_led2_duty:   led2_duty     <= data_out[7:0];
				lb_slave_pkg::wr_rx_hbank:    rx_mac_hbank  <= data_out[0];
				lb_slave_pkg::wr_misc_config: misc_config   <= data_out[7:0];
				default: ;
			endcase
		end
	end

	// Free-running PWM counter, carry out is the tick
	assign cc_next = {1'b0, led_cc} + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_cc   <= '0;
			led_tick <= 1'b0;
		end else begin
			led_cc   <= cc_next[led_cw-1:0];
			led_tick <= cc_next[led_cw];
		end
	end

	assign cc_ext    = cmp_w'(led_cc);
	assign duty1_ext = cmp_w'({led1_duty, 2'b00});
	assign duty2_ext = cmp_w'({led2_duty, 2'b00});

	// LED is on while the counter is below four times the duty factor
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= cc_ext < duty1_ext;
			led2 <= cc_ext < duty2_ext;
		end
	end

endmodule

`default_nettype wire

// File: hw/lb_mirror_ram.sv
/* Mirror memory for direct writes, simple dual port with registered read */
`timescale 1ns/100ps
`default_nettype none

module lb_mirror_ram #(
	parameter int mirror_aw = 5
) (
	input  wire                  clk,
	input  wire  [mirror_aw-1:0] wr_addr,
	input  wire                  wr_en,
	input  wire  [lb_slave_pkg::lb_data_w-1:0] wr_data,
	input  wire  [mirror_aw-1:0] rd_addr,
	output logic [lb_slave_pkg::lb_data_w-1:0] rd_data
);

	logic [lb_slave_pkg::lb_data_w-1:0] mem [2**mirror_aw];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read returns the old word when both ports hit the same address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hw/lb_read_mux.sv
/* Second read cycle
   Picks the status word, the mirror word or the unmapped value by page */
`timescale 1ns/100ps
`default_nettype none

module lb_read_mux (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [lb_slave_pkg::lb_addr_w-1:0] addr_r,
	input  wire         rd_r,
	input  wire  [lb_slave_pkg::lb_data_w-1:0] bank_word,
	input  wire  [lb_slave_pkg::lb_data_w-1:0] mirror_word,
	output logic [lb_slave_pkg::lb_data_w-1:0] data_in
);

	logic [7:0]                         page;
	logic [lb_slave_pkg::lb_data_w-1:0] sel_word;

	assign page = addr_r[lb_slave_pkg::lb_addr_w-1:16];

	always_comb begin
		case (page)
			lb_slave_pkg::page_status: sel_word = bank_word;
			lb_slave_pkg::page_direct: sel_word = mirror_word;
			default:                   sel_word = lb_slave_pkg::unmapped_value;
		endcase
	end

	// Result holds until the next read reaches this stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_in <= '0;
		end else if (rd_r) begin
			data_in <= sel_word;
		end
	end

endmodule

`default_nettype wire

// File: hw/lb_slave_top.sv
/* Board controller register block on the local bus
   Two-cycle read pipeline over the status bank, control bank and mirror */
`timescale 1ns/100ps
`default_nettype none

module lb_slave_top #(
	parameter int led_cw    = 10,
	parameter int mirror_aw = 5
) (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [lb_slave_pkg::lb_addr_w-1:0] addr,
	input  wire         control_strobe,
	input  wire         control_rd,
	input  wire  [lb_slave_pkg::lb_data_w-1:0] data_out,
	output logic [lb_slave_pkg::lb_data_w-1:0] data_in,
	input  wire         xdomain_fault,
	input  wire         tx_mac_done,
	input  wire  [1:0]  rx_mac_buf_status,
	output logic        rx_mac_hbank,
	output logic        led_user_mode,
	output logic        led1,
	output logic        led2,
	output logic [7:0]  misc_config
);

	logic                               do_rd;
	logic                               rd_r;
	logic [lb_slave_pkg::lb_addr_w-1:0] addr_r;
	logic                               local_write;
	logic                               led_tick;
	logic [lb_slave_pkg::lb_data_w-1:0] bank_word;
	logic [lb_slave_pkg::lb_data_w-1:0] mirror_word;

	assign do_rd = control_strobe & control_rd;

	// First pipeline stage for the read strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_r <= 1'b0;
		end else begin
			rd_r <= do_rd;
		end
	end

	// Address follows the strobe so the second stage sees the matching page
	always_ff @(posedge clk) begin
		addr_r <= addr;
	end

	lb_status_bank i_status_bank (
		.clk               (clk),
		.arst_n            (arst_n),
		.addr              (addr[3:0]),
		.do_rd             (do_rd),
		.xdomain_fault     (xdomain_fault),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.led_tick          (led_tick),
		.bank_word         (bank_word)
	);

	lb_ctrl_bank #(
		.led_cw (led_cw)
	) i_ctrl_bank (
		.clk            (clk),
		.arst_n         (arst_n),
		.addr           (addr),
		.control_strobe (control_strobe),
		.control_rd     (control_rd),
		.data_out       (data_out),
		.local_write    (local_write),
		.led_tick       (led_tick),
		.led_user_mode  (led_user_mode),
		.led1           (led1),
		.led2           (led2),
		.rx_mac_hbank   (rx_mac_hbank),
		.misc_config    (misc_config)
	);

	// Read port on the live address lines up with rd_r
	lb_mirror_ram #(
		.mirror_aw (mirror_aw)
	) i_mirror_ram (
		.clk     (clk),
		.wr_addr (addr[mirror_aw-1:0]),
		.wr_en   (local_write),
		.wr_data (data_out),
		.rd_addr (addr[mirror_aw-1:0]),
		.rd_data (mirror_word)
	);

	lb_read_mux i_read_mux (
		.clk         (clk),
		.arst_n      (arst_n),
		.addr_r      (addr_r),
		.rd_r        (rd_r),
		.bank_word   (bank_word),
		.mirror_word (mirror_word),
		.data_in     (data_in)
	);

endmodule

`default_nettype wire

// File: testbench/lb_slave_checker.sv
/* Checker for the local bus register block
   Models the mirror, fault count and uptime, and compares reads, levels and PWM */
`timescale 1ns/100ps
`default_nettype none

module lb_slave_checker #(
	parameter int led_cw    = 6,
	parameter int mirror_aw = 5
) (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [23:0] addr,
	input  wire         control_strobe,
	input  wire         control_rd,
	input  wire  [31:0] data_out,
	input  wire  [31:0] data_in,
	input  wire         xdomain_fault,
	input  wire         led1,
	input  wire         led2,
	input  wire         led_user_mode,
	input  wire         rx_mac_hbank,
	input  wire  [7:0]  misc_config,
	input  wire  [31:0] test_exp,
	input  wire         exp_from_table,
	input  wire         level_check,
	input  wire         pwm_window,
	output logic        in_flight
);

	localparam int tick_period = 2 ** led_cw;

	logic [31:0] mirror [2**mirror_aw];
	logic [15:0] fault_model;
	logic [31:0] uptime_prev;
	int          uptime_cyc;
	bit          uptime_seen;
	int          cycle;
	int          pwm_count;
	logic        window_r;
	int          check_count;
	int          error_count;

	// Two-entry read pipeline: valid, expected, address, uptime flag, strobe cycle
	logic        v0;
	logic        v1;
	logic [31:0] e0;
	logic [31:0] e1;
	logic [23:0] a0;
	logic [23:0] a1;
	logic        u0;
	logic        u1;
	int          c0;
	int          c1;

	assign in_flight = v0 | v1;

	initial begin
		check_count = 0;
		error_count = 0;
		uptime_seen = 1'b0;
	end

	task automatic report(input string what, input logic [31:0] got, input logic [31:0] want);
		check_count++;
		if (got === want) begin
			$display("%0t ns: %s = %h ok", $time, what, got);
		end else begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s returned %h, expected %h",
				$time, what, got, want);
		end
	endtask

	// Uptime reads compare against the previous one, one tick per counter period
	task automatic check_read(input logic [23:0] a, input logic [31:0] e, input bit up,
		input int c);
		logic [31:0] want;
		want = e;
		if (up && !uptime_seen) begin
			check_count++;
			$display("%0t ns: uptime reference %0d", $time, data_in);
		end else begin
			if (up) begin
				want = uptime_prev + 32'((c - uptime_cyc) / tick_period);
			end
			report($sformatf("read %h", a), data_in, want);
		end
		if (up) begin
			uptime_seen = 1'b1;
			uptime_prev = data_in;
			uptime_cyc  = c;
		end
	endtask

	always @(posedge clk) begin
		if (!arst_n) begin
			v0          <= 1'b0;
			v1          <= 1'b0;
			fault_model <= 16'd0;
			window_r    <= 1'b0;
			pwm_count   <= 0;
			cycle       <= 0;
		end else begin
			cycle <= cycle + 1;
			if (v1) begin
				check_read(a1, e1, u1, c1);
			end
			v1 <= v0;
			e1 <= e0;
			a1 <= a0;
			u1 <= u0;
			c1 <= c0;
			v0 <= control_strobe & control_rd;
			a0 <= addr;
			c0 <= cycle;
			u0 <= !exp_from_table && addr[23:16] == 8'd0 && addr[3:0] == 4'd8;
			if (exp_from_table) begin
				e0 <= test_exp;
			end else if (addr[23:16] == 8'd5) begin
				e0 <= mirror[addr[mirror_aw-1:0]];
			end else begin
				e0 <= {16'd0, fault_model};
			end
			if (control_strobe && !control_rd && addr[23:16] == 8'd5) begin
				mirror[addr[mirror_aw-1:0]] <= data_out;
			end
			if (xdomain_fault) begin
				fault_model <= fault_model + 16'd1;
			end
			if (level_check) begin
				report("outputs", {20'd0, misc_config, rx_mac_hbank, led_user_mode, led2, led1},
					{20'd0, test_exp[11:0]});
			end
			// High cycles of led1 over the window
			window_r <= pwm_window;
			if (pwm_window) begin
				pwm_count <= pwm_count + int'(led1);
			end else if (window_r) begin
				report("led1 high cycles", 32'(pwm_count), test_exp);
				pwm_count <= 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_lb_slave.sv
/* Testbench for the local bus register block
   Applies a stimulus table over the bus, the checker does the comparing */
`timescale 1ns/100ps
`default_nettype none

module tb_lb_slave;

	localparam int led_cw    = 6;
	localparam int mirror_aw = 5;
	localparam int max_entries = 48;

	// Table operations
	localparam logic [2:0] op_rd       = 3'd0;  // expected value from the table
	localparam logic [2:0] op_rd_model = 3'd1;  // expected value from the checker model
	localparam logic [2:0] op_wr       = 3'd2;
	localparam logic [2:0] op_wr_rand  = 3'd3;
	localparam logic [2:0] op_fault    = 3'd4;  // data is the number of pulse cycles
	localparam logic [2:0] op_pwm      = 3'd5;  // 64-cycle window on led1
	localparam logic [2:0] op_level    = 3'd6;  // {misc, hbank, user, led2, led1}
	localparam logic [2:0] op_idle     = 3'd7;  // data is the number of cycles

	logic        clk;
	logic        arst_n;
	logic [23:0] addr;
	logic        control_strobe;
	logic        control_rd;
	logic [31:0] data_out;
	logic [31:0] data_in;
	logic        xdomain_fault;
	logic        tx_mac_done;
	logic [1:0]  rx_mac_buf_status;
	logic        rx_mac_hbank;
	logic        led_user_mode;
	logic        led1;
	logic        led2;
	logic [7:0]  misc_config;
	logic [31:0] test_exp;
	logic        exp_from_table;
	logic        level_check;
	logic        pwm_window;
	logic        in_flight;

	logic [2:0]  tab_op   [max_entries];
	logic [23:0] tab_addr [max_entries];
	logic [31:0] tab_data [max_entries];
	logic [31:0] tab_exp  [max_entries];
	int          n_used;
	int          n_checks;
	int          cycles;
	integer      seed;

	lb_slave_top #(
		.led_cw    (led_cw),
		.mirror_aw (mirror_aw)
	) i_dut (
		.clk               (clk),
		.arst_n            (arst_n),
		.addr              (addr),
		.control_strobe    (control_strobe),
		.control_rd        (control_rd),
		.data_out          (data_out),
		.data_in           (data_in),
		.xdomain_fault     (xdomain_fault),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.rx_mac_hbank      (rx_mac_hbank),
		.led_user_mode     (led_user_mode),
		.led1              (led1),
		.led2              (led2),
		.misc_config       (misc_config)
	);

	lb_slave_checker #(
		.led_cw    (led_cw),
		.mirror_aw (mirror_aw)
	) i_checker (
		.clk            (clk),
		.arst_n         (arst_n),
		.addr           (addr),
		.control_strobe (control_strobe),
		.control_rd     (control_rd),
		.data_out       (data_out),
		.data_in        (data_in),
		.xdomain_fault  (xdomain_fault),
		.led1           (led1),
		.led2           (led2),
		.led_user_mode  (led_user_mode),
		.rx_mac_hbank   (rx_mac_hbank),
		.misc_config    (misc_config),
		.test_exp       (test_exp),
		.exp_from_table (exp_from_table),
		.level_check    (level_check),
		.pwm_window     (pwm_window),
		.in_flight      (in_flight)
	);

	task automatic add_entry(input logic [2:0] op, input logic [23:0] a, input logic [31:0] d,
		input logic [31:0] e);
		tab_op[n_used]   = op;
		tab_addr[n_used] = a;
		tab_data[n_used] = d;
		tab_exp[n_used]  = e;
		n_used++;
		if (op == op_rd || op == op_rd_model || op == op_pwm || op == op_level) begin
			n_checks++;
		end
	endtask

	task automatic fill_table();
		add_entry(op_level, 24'h000000, 0, 32'h008);
		add_entry(op_rd, 24'h000000, 0, "Hell");
		add_entry(op_rd, 24'h000001, 0, "o wo");
		add_entry(op_rd, 24'h000002, 0, "rld!");
		add_entry(op_rd, 24'h000003, 0, "(::)");
		add_entry(op_rd, 24'h00000e, 0, "zzzz");
		add_entry(op_rd, 24'h090000, 0, 32'hdeadbeef);
		add_entry(op_fault, 24'h000000, 5, 0);
		add_entry(op_rd, 24'h000004, 0, 32'd5);
		add_entry(op_fault, 24'h000000, 3, 0);
		add_entry(op_rd_model, 24'h000004, 0, 0);
		add_entry(op_rd, 24'h000006, 0, 32'd1);
		add_entry(op_rd, 24'h000007, 0, 32'd2);
		// Mirror indices away from the control registers
		add_entry(op_wr_rand, 24'h050000, 0, 0);
		add_entry(op_wr_rand, 24'h050009, 0, 0);
		add_entry(op_wr_rand, 24'h050011, 0, 0);
		add_entry(op_wr_rand, 24'h05001f, 0, 0);
		add_entry(op_rd_model, 24'h050000, 0, 0);
		add_entry(op_rd_model, 24'h050009, 0, 0);
		add_entry(op_rd_model, 24'h050011, 0, 0);
		add_entry(op_rd_model, 24'h05001f, 0, 0);
		add_entry(op_wr, 24'h050001, 32'd1, 0);
		add_entry(op_level, 24'h000000, 0, 32'h00c);
		add_entry(op_wr, 24'h050005, 32'd0, 0);
		add_entry(op_level, 24'h000000, 0, 32'h004);
		add_entry(op_wr, 24'h050008, 32'ha5, 0);
		add_entry(op_level, 24'h000000, 0, 32'ha54);
		add_entry(op_wr, 24'h050002, 32'd10, 0);
		add_entry(op_pwm, 24'h000000, 0, 32'd40);
		add_entry(op_wr, 24'h050002, 32'd20, 0);
		add_entry(op_pwm, 24'h000000, 0, 32'd64);
		add_entry(op_wr, 24'h050002, 32'd0, 0);
		add_entry(op_pwm, 24'h000000, 0, 32'd0);
		// Four times this duty is past the counter range, so led2 stays on
		add_entry(op_wr, 24'h050003, 32'd20, 0);
		add_entry(op_idle, 24'h000000, 1, 0);
		add_entry(op_level, 24'h000000, 0, 32'ha56);
		// Uptime strobes 128 cycles apart
		add_entry(op_rd_model, 24'h000008, 0, 0);
		add_entry(op_idle, 24'h000000, 127, 0);
		add_entry(op_rd_model, 24'h000008, 0, 0);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (n_used == 0 || cycles < n_used * 80 + 100) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the stimulus table did not complete", cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b1;
		rx_mac_buf_status = 2'b10;
		test_exp = '0;
		exp_from_table = 1'b0;
		level_check = 1'b0;
		pwm_window = 1'b0;
		seed = 32'hde966ad5;
		n_used = 0;
		n_checks = 0;
		fill_table();
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		for (int i = 0; i < n_used; i++) begin
			@(posedge clk);
			#1;
			control_strobe = 1'b0;
			control_rd = 1'b0;
			level_check = 1'b0;
			addr = tab_addr[i];
			test_exp = tab_exp[i];
			exp_from_table = (tab_op[i] == op_rd);
			case (tab_op[i])
				op_rd, op_rd_model: begin
					control_strobe = 1'b1;
					control_rd = 1'b1;
				end
				op_wr, op_wr_rand: begin
					control_strobe = 1'b1;
					data_out = (tab_op[i] == op_wr) ? tab_data[i] : $random(seed);
				end
				op_fault: begin
					xdomain_fault = 1'b1;
					repeat (tab_data[i]) @(posedge clk);
					#1 xdomain_fault = 1'b0;
				end
				op_pwm: begin
					// New duty reaches led1 one cycle after the write
					repeat (2) @(posedge clk);
					#1 pwm_window = 1'b1;
					repeat (64) @(posedge clk);
					#1 pwm_window = 1'b0;
				end
				op_level: level_check = 1'b1;
				default: repeat (tab_data[i] - 1) @(posedge clk);
			endcase
		end
		@(posedge clk);
		#1;
		control_strobe = 1'b0;
		level_check = 1'b0;
		while (in_flight) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		$display("Tests run: %0d of %0d, errors: %0d", i_checker.check_count, n_checks,
			i_checker.error_count);
		if (i_checker.error_count == 0 && i_checker.check_count == n_checks) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hw/lb_slave_pkg.sv
hw/lb_status_bank.sv
hw/lb_ctrl_bank.sv
hw/lb_mirror_ram.sv
hw/lb_read_mux.sv
hw/lb_slave_top.sv
testbench/lb_slave_checker.sv
testbench/tb_lb_slave.sv

// File: Bender.yml
package:
  name: lb_slave

sources:
  - hw/lb_slave_pkg.sv
  - hw/lb_status_bank.sv
  - hw/lb_ctrl_bank.sv
  - hw/lb_mirror_ram.sv
  - hw/lb_read_mux.sv
  - hw/lb_slave_top.sv
  - target: test
    files:
      - testbench/lb_slave_checker.sv
      - testbench/tb_lb_slave.sv
